// File: design/mem_stage_cfg.svh
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// data and address width
`define MEM_DW 32

// upper physical address that marks the uncached device window
`define MEM_UNCACHE_TAG 16'h1faf

// lowest bit of the region tag inside the physical address
`define MEM_TAG_LSB 16

// kseg bits dropped by the fixed virtual to physical mapping
`define MEM_PADDR_MASK_BITS 3

`endif

// File: design/mem_stage_pkg.sv
package mem_stage_pkg;

    // cp0 cause codes seen by the memory stage
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,   // load or fetch address error
        EXC_ADES = 5'd5,   // store address error
        EXC_OV   = 5'd12   // arithmetic overflow
    } exc_code_e;

    // load/store selector as produced by the decoder
    typedef enum logic [2:0] {
        DM_SB  = 3'b000,
        DM_SH  = 3'b001,
        DM_SW  = 3'b010,
        DM_LB  = 3'b011,
        DM_LBU = 3'b100,
        DM_LH  = 3'b101,
        DM_LHU = 3'b110,
        DM_LW  = 3'b111
    } dm_sel_e;

endpackage

// File: design/mem1_exception.sv
`timescale 1ns/1ns
`include "mem_stage_cfg.svh"

module mem1_exception (
    input  logic                    overflow,
    input  logic                    exc_in,
    input  mem_stage_pkg::exc_code_e exc_code_in,
    input  logic                    dm_rd,
    input  logic                    dm_wr,
    input  mem_stage_pkg::dm_sel_e  dm_sel,
    input  logic [`MEM_DW-1:0]      alu_out,
    input  logic [`MEM_DW-1:0]      pc,
    output logic                    exception,
    output mem_stage_pkg::exc_code_e exc_code,
    output logic [`MEM_DW-1:0]      badvaddr
);
    import mem_stage_pkg::*;

    logic store_misalign;
    logic load_misalign;

    assign store_misalign = dm_wr && ((dm_sel == DM_SW && alu_out[1:0] != 2'b00) ||
                                      (dm_sel == DM_SH && alu_out[0]));

    assign load_misalign = dm_rd && ((dm_sel == DM_LW && alu_out[1:0] != 2'b00) ||
                                     ((dm_sel == DM_LH || dm_sel == DM_LHU) && alu_out[0]));

    // an upstream exception always wins, then ov, ades, adel
    always_comb begin
        exception = exc_in;
        exc_code  = exc_code_in;
        badvaddr  = pc;
        if (!exc_in) begin
            if (overflow) begin
                exception = 1'b1;
                exc_code  = EXC_OV;
                badvaddr  = '0;       // no address involved
            end else if (store_misalign) begin
                exception = 1'b1;
                exc_code  = EXC_ADES;
                badvaddr  = alu_out;
            end else if (load_misalign) begin
                exception = 1'b1;
                exc_code  = EXC_ADEL;
                badvaddr  = alu_out;
            end
        end
    end

    // the upstream code is consumed only when flagged, it must be resolved by then
    exc_code_known : assert final (!exception || !$isunknown(exc_code))
        else $error("exception raised with unknown exc_code");

endmodule

// File: design/mem1_access_prep.sv
`timescale 1ns/1ns
`include "mem_stage_cfg.svh"

module mem1_access_prep (
    input  logic [`MEM_DW-1:0]     alu_out,
    input  logic [`MEM_DW-1:0]     wdata,
    input  mem_stage_pkg::dm_sel_e dm_sel,
    input  logic                   dm_rd,
    input  logic                   dm_wr,
    input  logic                   exception,
    input  logic                   eret_flush,
    output logic [`MEM_DW-1:0]     paddr,
    output logic                   uncached,
    output logic                   access,
    output logic [3:0]             wstrb,
    output logic [`MEM_DW-1:0]     wdata_lane
);
    import mem_stage_pkg::*;

    logic [4:0] lane_shift;

    // unmapped segments just drop the segment bits
    assign paddr = {{`MEM_PADDR_MASK_BITS{1'b0}}, alu_out[`MEM_DW-`MEM_PADDR_MASK_BITS-1:0]};

    assign uncached = (paddr[`MEM_DW-1:`MEM_TAG_LSB] == `MEM_UNCACHE_TAG);

    assign access = (dm_rd || dm_wr) && !exception && !eret_flush;

    assign lane_shift = {paddr[1:0], 3'b000};   // byte offset in bits

    always_comb begin
        wstrb = 4'b0000;
        if (access && dm_wr) begin
            case (dm_sel)
                DM_SB:   wstrb = 4'b0001 << paddr[1:0];
                DM_SH:   wstrb = paddr[1] ? 4'b1100 : 4'b0011;
                DM_SW:   wstrb = 4'b1111;
                default: wstrb = 4'b0000;
            endcase
        end
    end

    always_comb begin
        case (dm_sel)
            DM_SB:   wdata_lane = {24'd0, wdata[7:0]} << lane_shift;
            DM_SH:   wdata_lane = {16'd0, wdata[15:0]} << {paddr[1], 4'b0000};
            default: wdata_lane = wdata;
        endcase
    end

endmodule

// File: design/mem_pipe_reg.sv
`timescale 1ns/1ns
`include "mem_stage_cfg.svh"

module mem_pipe_reg (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load,
    input  logic                     stall,
    input  logic [`MEM_DW-1:0]       pc,
    input  mem_stage_pkg::dm_sel_e   dm_sel,
    input  logic                     wr,
    input  logic                     exception,
    input  mem_stage_pkg::exc_code_e exc_code,
    input  logic [`MEM_DW-1:0]       badvaddr,
    input  logic [`MEM_DW-1:0]       paddr,
    input  logic                     uncached,
    input  logic                     access,
    input  logic [3:0]               wstrb,
    input  logic [`MEM_DW-1:0]       wdata,
    output logic                     valid,
    output logic [`MEM_DW-1:0]       m2_pc,
    output mem_stage_pkg::dm_sel_e   m2_dm_sel,
    output logic                     m2_wr,
    output logic                     m2_exception,
    output mem_stage_pkg::exc_code_e m2_exc_code,
    output logic [`MEM_DW-1:0]       m2_badvaddr,
    output logic [`MEM_DW-1:0]       m2_paddr,
    output logic                     m2_uncached,
    output logic                     m2_access,
    output logic [3:0]               m2_wstrb,
    output logic [`MEM_DW-1:0]       m2_wdata
);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (!stall) begin
            valid <= 1'b0;   // item retired, nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m2_pc        <= pc;
            m2_dm_sel    <= dm_sel;
            m2_wr        <= wr;
            m2_exception <= exception;
            m2_exc_code  <= exc_code;
            m2_badvaddr  <= badvaddr;
            m2_paddr     <= paddr;
            m2_uncached  <= uncached;
            m2_access    <= access;
            m2_wstrb     <= wstrb;
            m2_wdata     <= wdata;
        end
    end

    // the port sequencer relies on a frozen request while it waits for ack
    hold_under_stall : assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable({m2_pc, m2_paddr, m2_wdata, m2_wstrb, m2_access, m2_uncached}))
        else $error("MEM2 contents changed during stall");

endmodule

// File: design/mem2_port_ctrl.sv
`timescale 1ns/1ns
`include "mem_stage_cfg.svh"

module mem2_port_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid,
    input  logic                   m2_access,
    input  logic                   m2_uncached,
    input  logic                   m2_wr,
    input  logic [`MEM_DW-1:0]     m2_paddr,
    input  logic [`MEM_DW-1:0]     m2_wdata,
    input  logic [3:0]             m2_wstrb,
    input  mem_stage_pkg::dm_sel_e m2_dm_sel,
    input  logic                   dc_ack,
    input  logic                   uc_ack,
    input  logic [`MEM_DW-1:0]     dc_rdata,
    input  logic [`MEM_DW-1:0]     uc_rdata,
    output logic                   stall,
    output logic                   done,
    output logic [`MEM_DW-1:0]     rdata_ext,
    output logic                   dc_req,
    output logic                   dc_wr,
    output logic                   uc_req,
    output logic                   uc_wr,
    output logic [`MEM_DW-1:0]     dc_addr,
    output logic [`MEM_DW-1:0]     dc_wdata,
    output logic [`MEM_DW-1:0]     uc_addr,
    output logic [`MEM_DW-1:0]     uc_wdata,
    output logic [3:0]             dc_wstrb,
    output logic [3:0]             uc_wstrb
);
    import mem_stage_pkg::*;

    typedef enum logic [1:0] {PS_IDLE, PS_REQ, PS_RELEASE, PS_DONE} port_state_e;

    port_state_e        state;
    logic               ack_sel;
    logic [`MEM_DW-1:0] rdata_sel;
    logic [`MEM_DW-1:0] rdata_q;
    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;

    assign ack_sel   = m2_uncached ? uc_ack : dc_ack;
    assign rdata_sel = m2_uncached ? uc_rdata : dc_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= PS_IDLE;
        end else begin
            case (state)
                PS_IDLE:    if (valid) state <= m2_access ? PS_REQ : PS_DONE;
                PS_REQ:     if (ack_sel) state <= PS_RELEASE;
                PS_RELEASE: if (!ack_sel) state <= PS_DONE;   // wait for ack low
                default:    state <= PS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PS_REQ && ack_sel) begin
            rdata_q <= rdata_sel;
        end
    end

    assign done  = (state == PS_DONE);
    assign stall = valid && !done;

    // only the selected port sees the request
    assign dc_req   = (state == PS_REQ) && !m2_uncached;
    assign uc_req   = (state == PS_REQ) && m2_uncached;
    assign dc_wr    = m2_wr && !m2_uncached;
    assign uc_wr    = m2_wr && m2_uncached;
    assign dc_addr  = m2_uncached ? '0 : m2_paddr;
    assign uc_addr  = m2_uncached ? m2_paddr : '0;
    assign dc_wdata = m2_uncached ? '0 : m2_wdata;
    assign uc_wdata = m2_uncached ? m2_wdata : '0;
    assign dc_wstrb = m2_uncached ? 4'b0000 : m2_wstrb;
    assign uc_wstrb = m2_uncached ? m2_wstrb : 4'b0000;

    assign byte_sel = rdata_q[{m2_paddr[1:0], 3'b000} +: 8];
    assign half_sel = rdata_q[{m2_paddr[1], 4'b0000} +: 16];

    always_comb begin
        case (m2_dm_sel)
            DM_LB:   rdata_ext = {{24{byte_sel[7]}}, byte_sel};
            DM_LBU:  rdata_ext = {24'd0, byte_sel};
            DM_LH:   rdata_ext = {{16{half_sel[15]}}, half_sel};
            DM_LHU:  rdata_ext = {16'd0, half_sel};
            default: rdata_ext = rdata_q;   // lw and the unused store case
        endcase
    end

    // four-phase rule: a new request starts only once ack has dropped
    req_after_ack_low : assert property (@(posedge clk) disable iff (reset)
        $rose(dc_req || uc_req) |-> !(dc_ack || uc_ack))
        else $error("memory request raised while ack still high");

endmodule

// File: design/mem_stage_top.sv
`timescale 1ns/1ns
`include "mem_stage_cfg.svh"

module mem_stage_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`MEM_DW-1:0]       pc,
    input  logic [`MEM_DW-1:0]       alu_out,
    input  logic [`MEM_DW-1:0]       wdata,
    input  mem_stage_pkg::dm_sel_e   dm_sel,
    input  logic                     dm_rd,
    input  logic                     dm_wr,
    input  logic                     overflow,
    input  logic                     exc_in,
    input  mem_stage_pkg::exc_code_e exc_code_in,
    input  logic                     eret_flush,
    output logic                     output_valid,
    output logic [`MEM_DW-1:0]       out_pc,
    output logic [`MEM_DW-1:0]       out_rdata,
    output logic                     out_exception,
    output mem_stage_pkg::exc_code_e out_exc_code,
    output logic [`MEM_DW-1:0]       out_badvaddr,
    output logic                     dc_req,
    output logic                     dc_wr,
    output logic [`MEM_DW-1:0]       dc_addr,
    output logic [3:0]               dc_wstrb,
    output logic [`MEM_DW-1:0]       dc_wdata,
    input  logic [`MEM_DW-1:0]       dc_rdata,
    input  logic                     dc_ack,
    output logic                     uc_req,
    output logic                     uc_wr,
    output logic [`MEM_DW-1:0]       uc_addr,
    output logic [3:0]               uc_wstrb,
    output logic [`MEM_DW-1:0]       uc_wdata,
    input  logic [`MEM_DW-1:0]       uc_rdata,
    input  logic                     uc_ack
);
    import mem_stage_pkg::*;

    logic               exception;
    exc_code_e          exc_code;
    logic [`MEM_DW-1:0] badvaddr;
    logic [`MEM_DW-1:0] paddr;
    logic               uncached;
    logic               access;
    logic [3:0]         wstrb;
    logic [`MEM_DW-1:0] wdata_lane;
    logic               load;
    logic               stall;
    logic               valid;
    dm_sel_e            m2_dm_sel;
    logic               m2_wr;
    logic [`MEM_DW-1:0] m2_paddr;
    logic               m2_uncached;
    logic               m2_access;
    logic [3:0]         m2_wstrb;
    logic [`MEM_DW-1:0] m2_wdata;

    assign in_ready = !stall;
    assign load     = in_valid && in_ready;

    mem1_exception u_exception (
        .overflow(overflow), .exc_in(exc_in), .exc_code_in(exc_code_in),
        .dm_rd(dm_rd), .dm_wr(dm_wr), .dm_sel(dm_sel), .alu_out(alu_out), .pc(pc),
        .exception(exception), .exc_code(exc_code), .badvaddr(badvaddr)
    );

    mem1_access_prep u_access_prep (
        .alu_out(alu_out), .wdata(wdata), .dm_sel(dm_sel), .dm_rd(dm_rd), .dm_wr(dm_wr),
        .exception(exception), .eret_flush(eret_flush),
        .paddr(paddr), .uncached(uncached), .access(access), .wstrb(wstrb),
        .wdata_lane(wdata_lane)
    );

    mem_pipe_reg u_pipe_reg (
        .clk(clk), .reset(reset), .load(load), .stall(stall),
        .pc(pc), .dm_sel(dm_sel), .wr(dm_wr), .exception(exception), .exc_code(exc_code),
        .badvaddr(badvaddr), .paddr(paddr), .uncached(uncached), .access(access),
        .wstrb(wstrb), .wdata(wdata_lane),
        .valid(valid), .m2_pc(out_pc), .m2_dm_sel(m2_dm_sel), .m2_wr(m2_wr),
        .m2_exception(out_exception), .m2_exc_code(out_exc_code),
        .m2_badvaddr(out_badvaddr), .m2_paddr(m2_paddr), .m2_uncached(m2_uncached),
        .m2_access(m2_access), .m2_wstrb(m2_wstrb), .m2_wdata(m2_wdata)
    );

    mem2_port_ctrl u_port_ctrl (
        .clk(clk), .reset(reset), .valid(valid), .m2_access(m2_access),
        .m2_uncached(m2_uncached), .m2_wr(m2_wr), .m2_paddr(m2_paddr), .m2_wdata(m2_wdata),
        .m2_wstrb(m2_wstrb), .m2_dm_sel(m2_dm_sel),
        .dc_ack(dc_ack), .uc_ack(uc_ack), .dc_rdata(dc_rdata), .uc_rdata(uc_rdata),
        .stall(stall), .done(output_valid), .rdata_ext(out_rdata),
        .dc_req(dc_req), .dc_wr(dc_wr), .uc_req(uc_req), .uc_wr(uc_wr),
        .dc_addr(dc_addr), .dc_wdata(dc_wdata), .uc_addr(uc_addr), .uc_wdata(uc_wdata),
        .dc_wstrb(dc_wstrb), .uc_wstrb(uc_wstrb)
    );

endmodule

// File: test/mem_stage_checker.sv
`timescale 1ns/1ns
`include "mem_stage_cfg.svh"

module mem_stage_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic                     in_ready,
    input  logic [`MEM_DW-1:0]       pc, alu_out, wdata,
    input  mem_stage_pkg::dm_sel_e   dm_sel,
    input  logic                     dm_rd, dm_wr, overflow, exc_in, eret_flush,
    input  mem_stage_pkg::exc_code_e exc_code_in,
    input  logic                     output_valid, out_exception,
    input  logic [`MEM_DW-1:0]       out_pc, out_rdata, out_badvaddr,
    input  mem_stage_pkg::exc_code_e out_exc_code,
    input  logic                     dc_req, dc_wr, uc_req, uc_wr,
    input  logic [`MEM_DW-1:0]       dc_addr, dc_wdata, uc_addr, uc_wdata,
    input  logic [3:0]               dc_wstrb, uc_wstrb,
    output int                       error_count,
    output int                       retired_count
);
    import mem_stage_pkg::*;

    logic [31:0]  shadow [0:127];   // cached window, then uncached window
    logic [172:0] exp_q [$];
    logic         e_exc, e_acc, e_unc, e_load;
    logic [4:0]   e_code;
    logic [31:0]  e_bad, e_pc, e_paddr, e_wdata, e_rdata;
    logic [3:0]   e_strb;
    logic         req_seen, req_prev;
    int           i;

    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h0101_0103) ^ 32'h1e40_c35a;
    endfunction

    initial begin
        error_count   = 0;
        retired_count = 0;
        for (i = 0; i < 64; i++) begin
            shadow[i]      = initial_word(i << 2);
            shadow[64 + i] = initial_word({`MEM_UNCACHE_TAG, 16'h0000} | (i << 2));
        end
    end

    // expected outcome of one item; a store also updates the shadow memory
    function automatic logic [172:0] reference_result(
        input logic [31:0] item_pc, alu, wd,
        input dm_sel_e     sel,
        input logic        rd, wr, ov, exc, eret,
        input exc_code_e   code_in);
        logic [31:0] paddr, bad, lane, word, rdat;
        logic        unc, exc_o, acc, mis_st, mis_ld;
        exc_code_e   code;
        logic [3:0]  strb;
        logic [6:0]  idx;
        logic [7:0]  b;
        logic [15:0] h;
        int          k;
        paddr  = {3'b000, alu[28:0]};
        unc    = paddr[31:16] == `MEM_UNCACHE_TAG;
        mis_st = wr && ((sel == DM_SW && alu[1:0] != 2'b00) || (sel == DM_SH && alu[0]));
        mis_ld = rd && ((sel == DM_LW && alu[1:0] != 2'b00) ||
                        ((sel == DM_LH || sel == DM_LHU) && alu[0]));
        exc_o  = 1'b1;
        if (exc) begin
            code = code_in;
            bad  = item_pc;
        end else if (ov) begin
            code = EXC_OV;
            bad  = '0;
        end else if (mis_st || mis_ld) begin
            code = mis_st ? EXC_ADES : EXC_ADEL;   // store check ranks first
            bad  = alu;
        end else begin
            exc_o = 1'b0;
            code  = EXC_INT;
            bad   = '0;
        end
        acc = (rd || wr) && !exc_o && !eret;
        case (sel)
            DM_SB:   begin strb = 4'b0001 << paddr[1:0]; lane = {4{wd[7:0]}}; end
            DM_SH:   begin strb = paddr[1] ? 4'b1100 : 4'b0011; lane = {2{wd[15:0]}}; end
            DM_SW:   begin strb = 4'b1111; lane = wd; end
            default: begin strb = 4'b0000; lane = wd; end
        endcase
        if (!(acc && wr))
            strb = 4'b0000;
        idx  = {unc, paddr[7:2]};
        word = shadow[idx];
        b    = word[paddr[1:0] * 8 +: 8];
        h    = word[paddr[1] * 16 +: 16];
        case (sel)
            DM_LB:   rdat = {{24{b[7]}}, b};
            DM_LBU:  rdat = {24'd0, b};
            DM_LH:   rdat = {{16{h[15]}}, h};
            DM_LHU:  rdat = {16'd0, h};
            default: rdat = word;
        endcase
        for (k = 0; k < 4; k++)
            if (strb[k]) word[k * 8 +: 8] = lane[k * 8 +: 8];
        shadow[idx] = word;
        return {exc_o, code, bad, item_pc, acc, unc, paddr, strb, lane, acc && rd, rdat};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR t=%0t %s", $time, what);
        error_count++;
    endtask

    task automatic check_request();
        logic [31:0] mask;
        if (exp_q.size() == 0) begin
            report_error("memory request with no item in flight");
            return;
        end
        {e_exc, e_code, e_bad, e_pc, e_acc, e_unc, e_paddr, e_strb, e_wdata, e_load,
         e_rdata} = exp_q[0];
        mask = {{8{e_strb[3]}}, {8{e_strb[2]}}, {8{e_strb[1]}}, {8{e_strb[0]}}};
        if (req_seen)
            report_error($sformatf("second memory request for pc %h", e_pc));
        req_seen = 1'b1;
        if (!e_acc) begin
            report_error($sformatf("memory request for pc %h, which must not access", e_pc));
        end else if (uc_req != e_unc || dc_req == e_unc) begin
            report_error($sformatf("request for pc %h went to the wrong port", e_pc));
        end else if (e_unc) begin
            compare_value("uc_addr", uc_addr, e_paddr);
            compare_value("uc_wr", uc_wr, !e_load);
            compare_value("uc_wstrb", uc_wstrb, e_strb);
            compare_value("uc_wdata", uc_wdata & mask, e_wdata & mask);
        end else begin
            compare_value("dc_addr", dc_addr, e_paddr);
            compare_value("dc_wr", dc_wr, !e_load);
            compare_value("dc_wstrb", dc_wstrb, e_strb);
            compare_value("dc_wdata", dc_wdata & mask, e_wdata & mask);
        end
    endtask

    task automatic check_output();
        if (exp_q.size() == 0) begin
            report_error("output_valid with no item in flight");
            return;
        end
        {e_exc, e_code, e_bad, e_pc, e_acc, e_unc, e_paddr, e_strb, e_wdata, e_load,
         e_rdata} = exp_q.pop_front();
        retired_count++;
        if (e_acc && !req_seen)
            report_error($sformatf("no memory request was made for pc %h", e_pc));
        req_seen = 1'b0;
        compare_value("out_pc", out_pc, e_pc);
        compare_value("out_exception", out_exception, e_exc);
        if (e_exc) begin
            compare_value("out_exc_code", out_exc_code, e_code);
            compare_value("out_badvaddr", out_badvaddr, e_bad);
        end
        if (e_load)
            compare_value("out_rdata", out_rdata, e_rdata);
    endtask

    // inputs are sampled before the edge, as the DUT captures them
    always @(posedge clk) begin
        if (!reset && in_valid && in_ready)
            exp_q.push_back(reference_result(pc, alu_out, wdata, dm_sel, dm_rd, dm_wr,
                                             overflow, exc_in, eret_flush, exc_code_in));
    end

    always @(posedge clk) begin
        if (reset) begin
            req_seen = 1'b0;
            req_prev = 1'b0;
        end else begin
            if ((dc_req || uc_req) && !req_prev)
                check_request();
            req_prev = dc_req || uc_req;
            if (output_valid)
                check_output();
        end
    end

endmodule

// File: test/mem_stage_tb.sv
`timescale 1ns/1ns
`include "mem_stage_cfg.svh"

module mem_responder #(
    parameter logic [31:0] window_base = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    input  logic        wr,
    input  logic [31:0] addr,
    input  logic [3:0]  wstrb,
    input  logic [31:0] wdata,
    output logic        ack,
    output logic [31:0] rdata
);
    logic [31:0] mem [0:63];
    logic [31:0] word;
    integer      seed = 32'h1e40;
    int          wait_cnt;
    int          i;

    function automatic logic [31:0] initial_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h0101_0103) ^ 32'h1e40_c35a;
    endfunction

    initial begin
        ack      = 1'b0;
        rdata    = '0;
        wait_cnt = 2;
        for (i = 0; i < 64; i++)
            mem[i] = initial_word(window_base | (i << 2));
    end

    always @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else if (req && !ack) begin
            if (wait_cnt > 0) begin
                wait_cnt = wait_cnt - 1;
            end else begin
                word = mem[addr[7:2]];
                for (i = 0; i < 4; i++)
                    if (wr && wstrb[i]) word[i * 8 +: 8] = wdata[i * 8 +: 8];
                mem[addr[7:2]] = word;
                rdata <= word;
                ack   <= 1'b1;
                wait_cnt = $unsigned($random(seed)) % 6;   // delay of the next request
            end
        end else if (!req && ack) begin
            ack <= 1'b0;
        end
    end
endmodule

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int num_items   = 400;
    localparam int cycle_limit = num_items * 40;

    logic               clk, reset, in_valid, in_ready, output_valid;
    logic [`MEM_DW-1:0] pc, alu_out, wdata, out_pc, out_rdata, out_badvaddr;
    dm_sel_e            dm_sel;
    logic               dm_rd, dm_wr, overflow, exc_in, eret_flush, out_exception;
    exc_code_e          exc_code_in, out_exc_code;
    logic               dc_req, dc_wr, dc_ack, uc_req, uc_wr, uc_ack;
    logic [`MEM_DW-1:0] dc_addr, dc_wdata, dc_rdata, uc_addr, uc_wdata, uc_rdata;
    logic [3:0]         dc_wstrb, uc_wstrb;
    int                 error_count, retired_count;
    int                 sent = 0;
    int                 cycles;
    integer             seed = 32'h1e40;

    mem_stage_top DUT (.*);

    mem_stage_checker u_checker (.*);

    mem_responder #(.window_base(32'h0000_0000)) u_dcache (
        .clk(clk), .reset(reset), .req(dc_req), .wr(dc_wr), .addr(dc_addr),
        .wstrb(dc_wstrb), .wdata(dc_wdata), .ack(dc_ack), .rdata(dc_rdata)
    );

    mem_responder #(.window_base({`MEM_UNCACHE_TAG, 16'h0000})) u_uncache (
        .clk(clk), .reset(reset), .req(uc_req), .wr(uc_wr), .addr(uc_addr),
        .wstrb(uc_wstrb), .wdata(uc_wdata), .ack(uc_ack), .rdata(uc_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic drive_item();
        logic [7:0] offset;
        logic [2:0] kseg;
        logic       unc;
        dm_sel_e    sel;
        int         kind;
        kind   = $unsigned($random(seed)) % 16;
        sel    = dm_sel_e'($unsigned($random(seed)) % 8);
        offset = $random(seed);
        unc    = $random(seed);
        if (kind < 11) begin   // mostly aligned so loads and stores reach memory
            if (sel == DM_SW || sel == DM_LW)
                offset[1:0] = 2'b00;
            else if (sel == DM_SH || sel == DM_LH || sel == DM_LHU)
                offset[0] = 1'b0;
        end
        kseg = $random(seed);
        pc          <= 32'hbfc0_0000 + (sent << 2);
        alu_out     <= {kseg, 29'd0} |
                       {(unc ? `MEM_UNCACHE_TAG : 16'h0000), 8'h00, offset};
        wdata       <= $random(seed);
        dm_sel      <= sel;
        dm_wr       <= (kind != 15) && (sel == DM_SB || sel == DM_SH || sel == DM_SW);
        dm_rd       <= (kind != 15) && !(sel == DM_SB || sel == DM_SH || sel == DM_SW);
        eret_flush  <= (kind == 12);
        exc_in      <= (kind == 13);
        exc_code_in <= (kind == 13 && ($random(seed) & 1)) ? EXC_ADEL : EXC_INT;
        overflow    <= (kind == 14);
        in_valid    <= 1'b1;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            in_valid <= 1'b0;
        end else if (!in_valid || in_ready) begin
            if (sent < num_items && ($random(seed) & 7) != 0) begin
                drive_item();
                sent = sent + 1;
            end else begin
                in_valid <= 1'b0;   // bubble
            end
        end
    end

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        pc          = '0;
        alu_out     = '0;
        wdata       = '0;
        dm_sel      = DM_LW;
        dm_rd       = 1'b0;
        dm_wr       = 1'b0;
        overflow    = 1'b0;
        exc_in      = 1'b0;
        exc_code_in = EXC_INT;
        eret_flush  = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (retired_count < num_items && cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        repeat (4) @(posedge clk);   // catch stray output_valid pulses
        if (cycles >= cycle_limit)
            $display("run stopped at the cycle limit, items were still in flight");
        $display("items sent %0d, retired %0d, errors %0d", sent, retired_count, error_count);
        if (error_count == 0 && cycles < cycle_limit) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: mem_stage.f
+incdir+design
design/mem_stage_pkg.sv
design/mem1_exception.sv
design/mem1_access_prep.sv
design/mem_pipe_reg.sv
design/mem2_port_ctrl.sv
design/mem_stage_top.sv
test/mem_stage_checker.sv
test/mem_stage_tb.sv
